// File: hdl/gmii_defs.svh
`ifndef GMII_DEFS_SVH
`define GMII_DEFS_SVH

// Frame layout on the GMII line
`define GMII_PREAMBLE_LEN  16'd7     // 0x55 bytes ahead of the SFD
`define GMII_PREAMBLE_BYTE 8'h55
`define GMII_SFD           8'hD5     // Start-of-frame delimiter

// Smallest payload after padding, so that 60 + FCS gives a 64 byte frame
`define GMII_MIN_PAYLOAD   16'd60

`define GMII_FCS_LEN       16'd4     // Sent LSB first

// Lowest interframe gap the register block will store, in clocks
`define GMII_IFG_MIN       8'd12

// Ethernet CRC-32, bit reversed form for LSB-first shifting
`define CRC32_POLY         32'hEDB88320
`define CRC32_INIT         32'hFFFFFFFF

// The line carries the complement of the CRC register

`endif

// File: hdl/gmii_types_pkg.sv
package gmii_types_pkg;

   // One byte of the input stream
   typedef struct packed
   {
      logic [7:0] data;
      logic       last;      // Final payload byte of the frame
   } tx_byte_t;

   // Registered GMII transmit pins
   typedef struct packed
   {
      logic [7:0] txd;
      logic       tx_en;
      logic       tx_er;
   } gmii_out_t;

   // Framer sequence, one line byte per clock in every state but IDLE and GAP
   typedef enum logic [2:0]
   {
      IDLE,
      PREAMBLE,
      SFD,
      PAYLOAD,
      PAD,
      FCS,
      GAP
   } framer_state_e;

endpackage

// File: hdl/tx_ctrl_pkg.sv
package tx_ctrl_pkg;

   typedef enum logic [1:0]
   {
      REG_CTRL      = 2'd0,  // Bit 0 enable, bit 1 pad_en
      REG_IFG       = 2'd1,
      REG_FRAMES    = 2'd2,  // Write clears
      REG_UNDERRUNS = 2'd3   // Write clears
   } reg_addr_e;

   // Host side of the four-phase port
   typedef struct packed
   {
      logic        req;
      logic        we;
      reg_addr_e   addr;
      logic [15:0] wdata;
   } cfg_req_t;

   typedef struct packed
   {
      logic        ack;
      logic [15:0] rdata;    // Valid while ack is high
   } cfg_rsp_t;

   // Settings steering the framer
   typedef struct packed
   {
      logic       enable;
      logic       pad_en;
      logic [7:0] ifg_len;   // Gap length in clocks
   } tx_cfg_t;

endpackage

// File: hdl/crc32_gen.sv
`timescale 1ns/100ps
`include "gmii_defs.svh"

module crc32_gen
  (
   input  logic        GMII_GTX_CLK_int,
   input  logic        reset_i,
   input  logic        crc_clear_i,
   input  logic        crc_update_i,
   input  logic [7:0]  crc_byte_i,
   output logic [31:0] crc_value_o
   );

   logic [31:0] crc_q;

   // Fold one byte in, LSB first, as the bits go out on the wire
   function automatic logic [31:0] crc_step(input logic [31:0] crc_in,
                                            input logic [7:0]  data);
      logic [31:0] c;
      c = crc_in ^ {24'd0, data};
      for (int i = 0; i < 8; i++)
         c = c[0] ? ((c >> 1) ^ `CRC32_POLY) : (c >> 1);
      return c;
   endfunction

   always_ff @(posedge GMII_GTX_CLK_int)
   begin
      if (reset_i)
         crc_q <= `CRC32_INIT;
      else if (crc_clear_i)
         crc_q <= `CRC32_INIT;     // Start of a new frame
      else if (crc_update_i)
         crc_q <= crc_step(crc_q, crc_byte_i);
   end

   // Raw register, framer inverts it for the FCS
   assign crc_value_o = crc_q;

endmodule

// File: hdl/gmii_tx_framer.sv
`timescale 1ns/100ps
`include "gmii_defs.svh"

module gmii_tx_framer
  (
   input  logic                      GMII_GTX_CLK_int,
   input  logic                      reset_i,
   input  tx_ctrl_pkg::tx_cfg_t      cfg_i,
   input  gmii_types_pkg::tx_byte_t  tx_in_i,
   input  logic                      tx_valid_i,
   output logic                      tx_ready_o,
   output logic                      crc_clear_o,
   output logic                      crc_update_o,
   output logic [7:0]                crc_byte_o,
   input  logic [31:0]               crc_value_i,
   output gmii_types_pkg::gmii_out_t gmii_o,
   output logic                      frame_done_o,
   output logic                      underrun_o
   );

   import gmii_types_pkg::*;

   framer_state_e state_q, state_d;
   logic [15:0]   cnt_q, cnt_d;     // Preamble, payload, FCS or gap position
   gmii_out_t     line_d;           // Unregistered line word
   logic [31:0]   fcs;
   logic [15:0]   gap_last;

   assign fcs = ~crc_value_i;

   // The IDLE clock before the next preamble is part of the gap
   assign gap_last = {8'd0, cfg_i.ifg_len} - 16'd2;

   always_comb
   begin
      state_d      = state_q;
      cnt_d        = cnt_q;
      line_d       = '0;
      tx_ready_o   = 1'b0;
      crc_clear_o  = 1'b0;
      crc_update_o = 1'b0;
      crc_byte_o   = 8'h00;
      frame_done_o = 1'b0;
      underrun_o   = 1'b0;

      case (state_q)
         IDLE:
         begin
            cnt_d = '0;
            if (cfg_i.enable && tx_valid_i)
               state_d = PREAMBLE;   // Enable only looked at here
         end

         PREAMBLE:
         begin
            line_d.tx_en = 1'b1;
            line_d.txd   = `GMII_PREAMBLE_BYTE;
            cnt_d        = cnt_q + 16'd1;
            if (cnt_q == `GMII_PREAMBLE_LEN - 16'd1)
            begin
               state_d = SFD;
               cnt_d   = '0;
            end
         end

         SFD:
         begin
            line_d.tx_en = 1'b1;
            line_d.txd   = `GMII_SFD;
            crc_clear_o  = 1'b1;
            state_d      = PAYLOAD;
         end

         PAYLOAD:
         begin
            tx_ready_o   = 1'b1;
            line_d.tx_en = 1'b1;
            if (tx_valid_i)
            begin
               line_d.txd   = tx_in_i.data;
               crc_update_o = 1'b1;
               crc_byte_o   = tx_in_i.data;
               cnt_d        = cnt_q + 16'd1;   // Bytes taken so far
               if (tx_in_i.last)
               begin
                  if (cfg_i.pad_en && (cnt_d < `GMII_MIN_PAYLOAD))
                     state_d = PAD;
                  else
                  begin
                     state_d = FCS;
                     cnt_d   = '0;
                  end
               end
            end
            else
            begin
               // Source ran dry, poison the frame and skip the FCS
               line_d.tx_er = 1'b1;
               underrun_o   = 1'b1;
               state_d      = GAP;
               cnt_d        = '0;
            end
         end

         PAD:
         begin
            line_d.tx_en = 1'b1;               // Zero data from the default
            crc_update_o = 1'b1;
            cnt_d        = cnt_q + 16'd1;
            if (cnt_q == `GMII_MIN_PAYLOAD - 16'd1)
            begin
               state_d = FCS;
               cnt_d   = '0;
            end
         end

         FCS:
         begin
            line_d.tx_en = 1'b1;
            line_d.txd   = fcs[{cnt_q[1:0], 3'b000} +: 8];   // LSB first
            cnt_d        = cnt_q + 16'd1;
            if (cnt_q == `GMII_FCS_LEN - 16'd1)
            begin
               frame_done_o = 1'b1;
               state_d      = GAP;
               cnt_d        = '0;
            end
         end

         GAP:
         begin
            cnt_d = cnt_q + 16'd1;
            if (cnt_q >= gap_last)
               state_d = IDLE;
         end

         default:
            state_d = IDLE;
      endcase
   end

   always_ff @(posedge GMII_GTX_CLK_int)
   begin
      if (reset_i)
      begin
         state_q <= IDLE;
         cnt_q   <= '0;
         gmii_o  <= '0;
      end
      else
      begin
         state_q <= state_d;
         cnt_q   <= cnt_d;
         gmii_o  <= line_d;      // Output flops next to the pins
      end
   end

endmodule

// File: hdl/tx_config_regs.sv
`timescale 1ns/100ps
`include "gmii_defs.svh"

module tx_config_regs
  (
   input  logic                  GMII_GTX_CLK_int,
   input  logic                  reset_i,
   input  tx_ctrl_pkg::cfg_req_t cfg_req_i,
   output tx_ctrl_pkg::cfg_rsp_t cfg_rsp_o,
   output tx_ctrl_pkg::tx_cfg_t  cfg_o,
   input  logic                  frame_done_i,
   input  logic                  underrun_i
   );

   import tx_ctrl_pkg::*;

   logic        access;        // New request, not yet acknowledged
   logic        wr;
   logic        wr_frames;
   logic        wr_underruns;
   logic [15:0] frames_q;
   logic [15:0] underruns_q;
   logic [15:0] rdata;

   // Saturating count, a host write wins over an event
   function automatic logic [15:0] count_next(input logic [15:0] cnt,
                                              input logic        inc,
                                              input logic        clr);
      if (clr)
         return 16'd0;
      else if (inc && (cnt != 16'hFFFF))
         return cnt + 16'd1;
      else
         return cnt;
   endfunction

   assign access       = cfg_req_i.req && !cfg_rsp_o.ack;
   assign wr           = access && cfg_req_i.we;
   assign wr_frames    = wr && (cfg_req_i.addr == REG_FRAMES);
   assign wr_underruns = wr && (cfg_req_i.addr == REG_UNDERRUNS);

   always_comb
   begin
      case (cfg_req_i.addr)
         REG_CTRL:      rdata = {14'd0, cfg_o.pad_en, cfg_o.enable};
         REG_IFG:       rdata = {8'd0, cfg_o.ifg_len};
         REG_FRAMES:    rdata = frames_q;
         REG_UNDERRUNS: rdata = underruns_q;
         default:       rdata = 16'd0;
      endcase
   end

   always_ff @(posedge GMII_GTX_CLK_int)
   begin
      if (reset_i)
      begin
         cfg_rsp_o   <= '0;
         cfg_o       <= '{enable: 1'b0, pad_en: 1'b1, ifg_len: `GMII_IFG_MIN};
         frames_q    <= '0;
         underruns_q <= '0;
      end
      else
      begin
         if (access)
         begin
            cfg_rsp_o.ack   <= 1'b1;
            cfg_rsp_o.rdata <= rdata;
         end
         else if (!cfg_req_i.req)
            cfg_rsp_o.ack <= 1'b0;        // Host has let go of req

         if (wr && (cfg_req_i.addr == REG_CTRL))
         begin
            cfg_o.enable <= cfg_req_i.wdata[0];
            cfg_o.pad_en <= cfg_req_i.wdata[1];
         end
         if (wr && (cfg_req_i.addr == REG_IFG))
         begin
            if (cfg_req_i.wdata < {8'd0, `GMII_IFG_MIN})
               cfg_o.ifg_len <= `GMII_IFG_MIN;
            else if (cfg_req_i.wdata[15:8] != 8'd0)
               cfg_o.ifg_len <= 8'hFF;     // Field is only 8 bits wide
            else
               cfg_o.ifg_len <= cfg_req_i.wdata[7:0];
         end

         frames_q    <= count_next(frames_q, frame_done_i, wr_frames);
         underruns_q <= count_next(underruns_q, underrun_i, wr_underruns);
      end
   end

endmodule

// File: hdl/gmii_tx_top.sv
`timescale 1ns/100ps

module gmii_tx_top
  (
   input  logic                      GMII_GTX_CLK_int,
   input  logic                      reset_i,

   // Host register port
   input  tx_ctrl_pkg::cfg_req_t     cfg_req_i,
   output tx_ctrl_pkg::cfg_rsp_t     cfg_rsp_o,

   // Byte stream in
   input  gmii_types_pkg::tx_byte_t  tx_in_i,
   input  logic                      tx_valid_i,
   output logic                      tx_ready_o,

   // Registered GMII transmit pins
   output gmii_types_pkg::gmii_out_t gmii_o
   );

   import tx_ctrl_pkg::*;

   tx_cfg_t     cfg;
   logic        frame_done;
   logic        underrun;
   logic        crc_clear;
   logic        crc_update;
   logic [7:0]  crc_byte;
   logic [31:0] crc_value;

   tx_config_regs regs
     (.GMII_GTX_CLK_int (GMII_GTX_CLK_int),
      .reset_i          (reset_i),
      .cfg_req_i        (cfg_req_i),
      .cfg_rsp_o        (cfg_rsp_o),
      .cfg_o            (cfg),
      .frame_done_i     (frame_done),
      .underrun_i       (underrun));

   gmii_tx_framer framer
     (.GMII_GTX_CLK_int (GMII_GTX_CLK_int),
      .reset_i          (reset_i),
      .cfg_i            (cfg),
      .tx_in_i          (tx_in_i),
      .tx_valid_i       (tx_valid_i),
      .tx_ready_o       (tx_ready_o),
      .crc_clear_o      (crc_clear),
      .crc_update_o     (crc_update),
      .crc_byte_o       (crc_byte),
      .crc_value_i      (crc_value),
      .gmii_o           (gmii_o),
      .frame_done_o     (frame_done),
      .underrun_o       (underrun));

   crc32_gen crc
     (.GMII_GTX_CLK_int (GMII_GTX_CLK_int),
      .reset_i          (reset_i),
      .crc_clear_i      (crc_clear),
      .crc_update_i     (crc_update),
      .crc_byte_i       (crc_byte),
      .crc_value_o      (crc_value));

endmodule

// File: tb/tb_clk_gen.sv
`timescale 1ns/100ps

module tb_clk_gen
  (
   output logic clk_o,
   output logic reset_o
   );

   localparam int HALF_PERIOD  = 4;    // 8 ns clock
   localparam int RESET_CYCLES = 10;

   initial
   begin
      clk_o = 1'b0;
      forever
         #HALF_PERIOD clk_o = ~clk_o;
   end

   // Released just after a rising edge, the DUT reset is synchronous
   initial
   begin
      reset_o = 1'b1;
      repeat (RESET_CYCLES) @(posedge clk_o);
      #1 reset_o = 1'b0;
   end

endmodule

// File: tb/gmii_tx_tb.sv
`timescale 1ns/100ps
`include "gmii_defs.svh"

module gmii_tx_tb;

   import gmii_types_pkg::*;
   import tx_ctrl_pkg::*;

   localparam int NUM_CASES    = 8;
   localparam int CAP_MAX      = 2048;
   localparam int PAY_MAX      = 1024;
   localparam int ACK_LIMIT    = 16;
   localparam int RUN_OVERHEAD = 400;   // Reset plus register tests and the disabled phase

   // abort_at of 0 means the source never stalls
   typedef struct packed
   {
      int len;
      int pad_en;
      int ifg;
      int abort_at;
      int exp_frames;
      int exp_underruns;
   } frame_case_t;

   frame_case_t cases [NUM_CASES] = '{
      '{20,  1, 12, 0,  1, 0},    // Padded up to 60
      '{64,  1, 20, 0,  2, 0},
      '{10,  0, 5,  0,  3, 0},    // Unpadded with the gap clamped to 12
      '{30,  1, 16, 12, 3, 1},
      '{1,   1, 12, 0,  4, 1},
      '{100, 0, 30, 0,  5, 1},
      '{45,  0, 14, 7,  5, 2},
      '{59,  1, 13, 0,  6, 2}     // One pad byte
   };

   logic      GMII_GTX_CLK_int;
   logic      reset_i;
   cfg_req_t  cfg_req;
   cfg_rsp_t  cfg_rsp;
   tx_byte_t  tx_in;
   logic      tx_valid;
   logic      tx_ready;
   gmii_out_t gmii;

   integer     seed = 32'hc4a3;
   logic [7:0] pay_mem [PAY_MAX];
   int         pay_off [NUM_CASES];
   int         errors = 0;
   int         checks = 0;

   // Line capture
   logic [7:0] cap_txd [CAP_MAX];
   logic       cap_er [CAP_MAX];
   int         cap_idx = 0;
   int         frame_first [NUM_CASES];
   int         frame_last [NUM_CASES];    // One past the final byte
   int         gap_before [NUM_CASES];
   int         starts = 0;
   int         ends = 0;
   int         low_cnt = 0;
   logic       in_frame = 1'b0;

   tb_clk_gen clkgen
     (.clk_o   (GMII_GTX_CLK_int),
      .reset_o (reset_i));

   gmii_tx_top uut
     (.GMII_GTX_CLK_int (GMII_GTX_CLK_int),
      .reset_i          (reset_i),
      .cfg_req_i        (cfg_req),
      .cfg_rsp_o        (cfg_rsp),
      .tx_in_i          (tx_in),
      .tx_valid_i       (tx_valid),
      .tx_ready_o       (tx_ready),
      .gmii_o           (gmii));

   task automatic check_value(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
      checks++;
      if (got !== exp)
      begin
         errors++;
         $display("CHECK FAILED %s: got 0x%0h, expected 0x%0h", name, got, exp);
      end
   endtask

   function automatic int eff_ifg(input int c);
      return (cases[c].ifg < 12) ? 12 : cases[c].ifg;
   endfunction

   function automatic int table_cycles();
      int total;
      total = 0;
      for (int c = 0; c < NUM_CASES; c++)
         total += 12 + ((cases[c].len < 60) ? 60 : cases[c].len) + eff_ifg(c) + 40;
      return total;
   endfunction

   // Ethernet CRC in its normal MSB-first form with data bits entering LSB first
   function automatic logic [31:0] crc_ref_byte(input logic [31:0] crc,
                                                input logic [7:0]  b);
      logic [31:0] c;
      logic        fb;
      c = crc;
      for (int j = 0; j < 8; j++)
      begin
         fb = b[j] ^ c[31];
         c  = {c[30:0], 1'b0} ^ (fb ? 32'h04C11DB7 : 32'h0);
      end
      return c;
   endfunction

   function automatic logic [31:0] reflect32(input logic [31:0] v);
      logic [31:0] r;
      for (int j = 0; j < 32; j++)
         r[j] = v[31 - j];
      return r;
   endfunction

   // Four-phase access where ack must follow req both ways
   task automatic reg_access(input reg_addr_e addr, input logic we,
                             input logic [15:0] wdata, output logic [15:0] rdata);
      int wait_cnt;
      @(posedge GMII_GTX_CLK_int);
      #1;
      check_value("cfg_rsp.ack before req", cfg_rsp.ack, 0);
      cfg_req  = '{req: 1'b1, we: we, addr: addr, wdata: wdata};
      wait_cnt = 0;
      do
      begin
         @(negedge GMII_GTX_CLK_int);
         wait_cnt++;
      end
      while (!cfg_rsp.ack && wait_cnt < ACK_LIMIT);
      if (!cfg_rsp.ack)
      begin
         errors++;
         $display("Register port never acknowledged an access to %s", addr.name());
      end
      rdata = cfg_rsp.rdata;
      @(posedge GMII_GTX_CLK_int);
      #1;
      cfg_req.req = 1'b0;
      @(negedge GMII_GTX_CLK_int);
      check_value("cfg_rsp.ack held after req drop", cfg_rsp.ack, 1);
      wait_cnt = 0;
      while (cfg_rsp.ack && wait_cnt < ACK_LIMIT)
      begin
         @(negedge GMII_GTX_CLK_int);
         wait_cnt++;
      end
      if (cfg_rsp.ack)
      begin
         errors++;
         $display("Register port kept ack high after req was dropped");
      end
   endtask

   task automatic reg_write(input reg_addr_e addr, input logic [15:0] wdata);
      logic [15:0] unused;
      reg_access(addr, 1'b1, wdata, unused);
   endtask

   task automatic reg_expect(input reg_addr_e addr, input logic [15:0] exp);
      logic [15:0] rdata;
      reg_access(addr, 1'b0, 16'h0000, rdata);
      check_value($sformatf("%s rdata", addr.name()), rdata, exp);
   endtask

   task automatic apply_config(input int c);
      logic [15:0] ctrl;
      ctrl = {14'd0, cases[c].pad_en[0], 1'b1};
      reg_write(REG_CTRL, ctrl);   // Pad setting must land before the last payload byte
      reg_write(REG_IFG, cases[c].ifg[15:0]);
      reg_expect(REG_CTRL, ctrl);
   endtask

   task automatic send_frame(input int c);
      int   idx;
      logic taken;
      idx = 0;
      while (idx < cases[c].len)
      begin
         if (cases[c].abort_at != 0 && idx == cases[c].abort_at)
         begin
            // Stall mid-payload and drop the rest of this frame
            tx_valid = 1'b0;
            @(posedge GMII_GTX_CLK_int);
            #1;
            return;
         end
         tx_valid = 1'b1;
         tx_in    = '{data: pay_mem[pay_off[c] + idx], last: (idx == cases[c].len - 1)};
         @(negedge GMII_GTX_CLK_int);
         taken = tx_ready;
         @(posedge GMII_GTX_CLK_int);
         #1;
         if (taken)
            idx++;
      end
   endtask

   task automatic stream_frames();
      @(posedge GMII_GTX_CLK_int);
      #1;
      for (int c = 0; c < NUM_CASES; c++)
         send_frame(c);
      tx_valid = 1'b0;
   endtask

   task automatic check_frame(input int i);
      int          plen;
      int          exp_len;
      int          got_len;
      int          base;
      logic [7:0]  exp_txd;
      logic        exp_er;
      logic [31:0] crc;
      logic [31:0] fcs;
      plen = cases[i].len;
      if (cases[i].pad_en != 0 && plen < `GMII_MIN_PAYLOAD)
         plen = `GMII_MIN_PAYLOAD;
      if (cases[i].abort_at != 0)
         exp_len = 8 + cases[i].abort_at + 1;   // Poisoned byte and no FCS
      else
         exp_len = 8 + plen + 4;
      base    = frame_first[i];
      got_len = frame_last[i] - base;
      check_value($sformatf("frame %0d tx_en high cycles", i), got_len, exp_len);
      crc = 32'hFFFFFFFF;
      for (int p = 0; p < exp_len && p < got_len; p++)
      begin
         exp_er = 1'b0;
         if (p < 7)
            exp_txd = 8'h55;
         else if (p == 7)
            exp_txd = 8'hD5;
         else if (cases[i].abort_at != 0 && p == 8 + cases[i].abort_at)
         begin
            exp_txd = 8'h00;
            exp_er  = 1'b1;
         end
         else if (p < 8 + plen)
         begin
            exp_txd = (p - 8 < cases[i].len) ? pay_mem[pay_off[i] + p - 8] : 8'h00;
            crc     = crc_ref_byte(crc, exp_txd);
         end
         else
         begin
            fcs     = ~reflect32(crc);
            exp_txd = fcs[8 * (p - 8 - plen) +: 8];   // LSB first
         end
         check_value($sformatf("frame %0d byte %0d gmii_o.txd", i, p), cap_txd[base + p],
                     exp_txd);
         check_value($sformatf("frame %0d byte %0d gmii_o.tx_er", i, p), cap_er[base + p],
                     exp_er);
      end
   endtask

   // Record line bytes and low times
   always @(negedge GMII_GTX_CLK_int)
   begin
      if (!reset_i)
      begin
         if (gmii.tx_en)
         begin
            if (!in_frame)
            begin
               if (starts < NUM_CASES)
               begin
                  frame_first[starts] = cap_idx;
                  gap_before[starts]  = low_cnt;
               end
               starts++;
               in_frame = 1'b1;
            end
            if (cap_idx < CAP_MAX)
            begin
               cap_txd[cap_idx] = gmii.txd;
               cap_er[cap_idx]  = gmii.tx_er;
               cap_idx++;
            end
         end
         else
         begin
            if (in_frame)
            begin
               if (ends < NUM_CASES)
                  frame_last[ends] = cap_idx;
               ends++;
               in_frame = 1'b0;
               low_cnt  = 0;
            end
            low_cnt++;
         end
      end
   end

   initial
   begin
      int          limit_ns;
      int          off;
      logic [31:0] rnd;
      cfg_req  = '0;
      tx_in    = '0;
      tx_valid = 1'b0;

      off = 0;
      for (int c = 0; c < NUM_CASES; c++)
      begin
         pay_off[c] = off;
         for (int j = 0; j < cases[c].len; j++)
         begin
            rnd              = $random(seed);
            pay_mem[off + j] = rnd[7:0];
         end
         off += cases[c].len;
      end

      limit_ns = 8 * (RUN_OVERHEAD + table_cycles());
      fork
         begin
            #(limit_ns);
            $display("Timeout: run did not finish within %0d ns", limit_ns);
            $display("Simulation failed");
            $finish;
         end
      join_none

      wait (reset_i === 1'b0);
      fork
         stream_frames();
      join_none

      // Register port straight after reset
      reg_expect(REG_CTRL, 16'h0002);
      reg_expect(REG_IFG, 16'd12);
      reg_write(REG_IFG, 16'd5);
      reg_expect(REG_IFG, 16'd12);
      reg_write(REG_IFG, 16'd40);
      reg_expect(REG_IFG, 16'd40);
      reg_write(REG_CTRL, 16'h0000);
      reg_expect(REG_CTRL, 16'h0000);
      reg_write(REG_CTRL, 16'h0002);
      reg_expect(REG_CTRL, 16'h0002);

      // Source offers the first byte but nothing may move while disabled
      for (int n = 0; n < 20; n++)
      begin
         @(negedge GMII_GTX_CLK_int);
         check_value("gmii_o.tx_en while disabled", gmii.tx_en, 0);
         check_value("tx_ready_o while disabled", tx_ready, 0);
      end

      apply_config(0);
      for (int c = 0; c < NUM_CASES; c++)
      begin
         while (starts <= c)
            @(posedge GMII_GTX_CLK_int);
         if (c > 0)
            apply_config(c);
         while (ends <= c)
            @(posedge GMII_GTX_CLK_int);
         reg_expect(REG_FRAMES, cases[c].exp_frames[15:0]);       // Read inside the gap
         reg_expect(REG_UNDERRUNS, cases[c].exp_underruns[15:0]);
      end

      reg_write(REG_FRAMES, 16'h0000);
      reg_write(REG_UNDERRUNS, 16'h0000);
      reg_expect(REG_FRAMES, 16'h0000);
      reg_expect(REG_UNDERRUNS, 16'h0000);

      check_value("frames seen on the line", starts, NUM_CASES);
      for (int c = 0; c < NUM_CASES; c++)
         if (c < ends)
            check_frame(c);
      for (int c = 0; c + 1 < NUM_CASES; c++)
         if (c + 1 < starts)
            check_value($sformatf("gap after frame %0d", c), gap_before[c + 1], eff_ifg(c));

      $display("Checks: %0d, errors: %0d", checks, errors);
      if (errors == 0)
         $display("Simulation completed successfully");
      else
         $display("Simulation failed");
      $finish;
   end

endmodule

// File: files.f
+incdir+hdl
hdl/gmii_types_pkg.sv
hdl/tx_ctrl_pkg.sv
hdl/crc32_gen.sv
hdl/gmii_tx_framer.sv
hdl/tx_config_regs.sv
hdl/gmii_tx_top.sv
tb/tb_clk_gen.sv
tb/gmii_tx_tb.sv

// File: Makefile
# Verilator build and run for the GMII transmit path

VERILATOR ?= verilator
TOP       ?= gmii_tx_tb
FILELIST  ?= files.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -j 0 -Wno-fatal

SOURCES := $(wildcard hdl/*.sv hdl/*.svh tb/*.sv)
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	./$(SIM_BIN) 2>&1 | tee $(LOG)
	@if grep -q "Simulation failed" $(LOG); then \
		echo "Run failed, see $(LOG)"; exit 1; \
	fi
	@grep -q "Simulation completed successfully" $(LOG) || \
		{ echo "No pass message in $(LOG)"; exit 1; }

clean:
	rm -rf $(BUILD_DIR) $(LOG)
